//--- ib_msg_pkg.sv
package ib_msg_pkg;

	// Source of the outgoing variable-to-check messages.
	// The first iteration bypasses the channel LLR to every edge.
	typedef enum logic {
		V2C_SRC_EXTRINSIC = 1'b0,
		V2C_SRC_CHANNEL   = 1'b1
	} v2c_src_e;

	// Cycles from an accepted msg_valid to v2c_valid
	// Two decomposed lookup stages plus the output register
	localparam int VNU_LATENCY = 3;

endpackage

//--- ib_ctrl_pkg.sv
package ib_ctrl_pkg;

	// Iteration controller states
	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		// Outgoing messages carry the channel LLR
		FIRST_ITER = 2'd1,
		// Outgoing messages carry the extrinsic result
		ITERATE    = 2'd2,
		// One cycle, done pulses here
		FINISH     = 2'd3
	} ctrl_state_e;

endpackage

//--- ib_lut2_stage.sv
`timescale 1ns/1ps

module ib_lut2_stage #(
	parameter int QUAN_SIZE = 4
) (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic [QUAN_SIZE-1:0] in_a,
	input  logic [QUAN_SIZE-1:0] in_b,
	output logic [QUAN_SIZE-1:0] out
);

	// Two guard bits hold the sum of two levels without overflow
	localparam int SUM_W = QUAN_SIZE + 2;
	localparam logic signed [SUM_W-1:0] OFFSET  = SUM_W'(2 ** (QUAN_SIZE - 1));
	localparam logic signed [SUM_W-1:0] LVL_MAX = OFFSET - SUM_W'(1);
	localparam logic signed [SUM_W-1:0] LVL_MIN = -OFFSET;

	logic signed [SUM_W-1:0] lvl_a;
	logic signed [SUM_W-1:0] lvl_b;
	logic signed [SUM_W-1:0] lvl_sum;
	logic signed [SUM_W-1:0] lvl_sat;

	// Offset-binary index to signed level
	assign lvl_a   = signed'(SUM_W'(in_a)) - OFFSET;
	assign lvl_b   = signed'(SUM_W'(in_b)) - OFFSET;
	assign lvl_sum = lvl_a + lvl_b;

	// Clamp to the signed message range
	assign lvl_sat = (lvl_sum > LVL_MAX) ? LVL_MAX :
	                 (lvl_sum < LVL_MIN) ? LVL_MIN : lvl_sum;

	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			out <= '0;
		end else begin
			// Back to an offset-binary index
			out <= QUAN_SIZE'(lvl_sat + OFFSET);
		end
	end

endmodule

//--- c2v_delay_line.sv
`timescale 1ns/1ps

module c2v_delay_line
	import ib_msg_pkg::*;
#(
	parameter int QUAN_SIZE = 4,
	parameter int DEPTH     = 2
) (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic [QUAN_SIZE-1:0] msg_in,
	input  v2c_src_e             tag_in,
	input  logic                 vld_in,
	output logic [QUAN_SIZE-1:0] msg_out,
	output v2c_src_e             tag_out,
	output logic                 vld_out
);

	logic [QUAN_SIZE-1:0] msg_q [DEPTH];
	v2c_src_e             tag_q [DEPTH];
	logic [DEPTH-1:0]     vld_q;

	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			for (int i = 0; i < DEPTH; i++) begin
				msg_q[i] <= '0;
				tag_q[i] <= V2C_SRC_EXTRINSIC;
			end
			vld_q <= '0;
		end else begin
			msg_q[0] <= msg_in;
			tag_q[0] <= tag_in;
			vld_q[0] <= vld_in;
			// Message, tag and valid move together one stage per cycle
			for (int i = 1; i < DEPTH; i++) begin
				msg_q[i] <= msg_q[i-1];
				tag_q[i] <= tag_q[i-1];
				vld_q[i] <= vld_q[i-1];
			end
		end
	end

	assign msg_out = msg_q[DEPTH-1];
	assign tag_out = tag_q[DEPTH-1];
	assign vld_out = vld_q[DEPTH-1];

endmodule

//--- vnu3_datapath.sv
`timescale 1ns/1ps

module vnu3_datapath
	import ib_msg_pkg::*;
#(
	parameter int QUAN_SIZE = 4
) (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic                 msg_valid,
	input  v2c_src_e             v2c_src,
	input  logic [QUAN_SIZE-1:0] ch_llr,
	input  logic [QUAN_SIZE-1:0] c2v0,
	input  logic [QUAN_SIZE-1:0] c2v1,
	input  logic [QUAN_SIZE-1:0] c2v2,
	output logic                 v2c_valid,
	output logic [QUAN_SIZE-1:0] v2c0,
	output logic [QUAN_SIZE-1:0] v2c1,
	output logic [QUAN_SIZE-1:0] v2c2,
	output logic                 hard_bit
);

	// The channel LLR and the tag wait until the output register
	localparam int CH_DEPTH = VNU_LATENCY - 1;

	logic [QUAN_SIZE-1:0] ta, tb;
	logic [QUAN_SIZE-1:0] m0, m1, m2, td;
	logic [QUAN_SIZE-1:0] dec_idx;
	logic [QUAN_SIZE-1:0] e1_d1, e2_d1, e2_d2;
	logic [QUAN_SIZE-1:0] ch_d2;
	v2c_src_e             tag_d2;
	logic                 vld_d2;

	////////////////////
	// Delay lines
	c2v_delay_line #(.QUAN_SIZE(QUAN_SIZE), .DEPTH(CH_DEPTH)) i_ch_dly (
		.read_clk(read_clk), .rstn(rstn),
		.msg_in(ch_llr), .tag_in(v2c_src), .vld_in(msg_valid),
		.msg_out(ch_d2), .tag_out(tag_d2), .vld_out(vld_d2)
	);

	// E1 and E2 only need the message, their tag copies stay open
	c2v_delay_line #(.QUAN_SIZE(QUAN_SIZE), .DEPTH(1)) i_e1_dly (
		.read_clk(read_clk), .rstn(rstn),
		.msg_in(c2v1), .tag_in(v2c_src), .vld_in(msg_valid),
		.msg_out(e1_d1), .tag_out(), .vld_out()
	);

	c2v_delay_line #(.QUAN_SIZE(QUAN_SIZE), .DEPTH(1)) i_e2_dly1 (
		.read_clk(read_clk), .rstn(rstn),
		.msg_in(c2v2), .tag_in(v2c_src), .vld_in(msg_valid),
		.msg_out(e2_d1), .tag_out(), .vld_out()
	);

	c2v_delay_line #(.QUAN_SIZE(QUAN_SIZE), .DEPTH(1)) i_e2_dly2 (
		.read_clk(read_clk), .rstn(rstn),
		.msg_in(e2_d1), .tag_in(v2c_src), .vld_in(msg_valid),
		.msg_out(e2_d2), .tag_out(), .vld_out()
	);

	////////////////////
	// Stage 1
	ib_lut2_stage #(.QUAN_SIZE(QUAN_SIZE)) i_lut_ta (
		.read_clk(read_clk), .rstn(rstn), .in_a(ch_llr), .in_b(c2v0), .out(ta)
	);
	ib_lut2_stage #(.QUAN_SIZE(QUAN_SIZE)) i_lut_tb (
		.read_clk(read_clk), .rstn(rstn), .in_a(ch_llr), .in_b(c2v1), .out(tb)
	);

	////////////////////
	// Stage 2
	// m0 excludes E0, m1 excludes E1, m2 excludes E2
	ib_lut2_stage #(.QUAN_SIZE(QUAN_SIZE)) i_lut_m0 (
		.read_clk(read_clk), .rstn(rstn), .in_a(tb), .in_b(e2_d1), .out(m0)
	);
	ib_lut2_stage #(.QUAN_SIZE(QUAN_SIZE)) i_lut_m1 (
		.read_clk(read_clk), .rstn(rstn), .in_a(ta), .in_b(e2_d1), .out(m1)
	);
	ib_lut2_stage #(.QUAN_SIZE(QUAN_SIZE)) i_lut_m2 (
		.read_clk(read_clk), .rstn(rstn), .in_a(ta), .in_b(e1_d1), .out(m2)
	);
	// Decision path keeps its own copy of ta + E1
	ib_lut2_stage #(.QUAN_SIZE(QUAN_SIZE)) i_lut_td (
		.read_clk(read_clk), .rstn(rstn), .in_a(ta), .in_b(e1_d1), .out(td)
	);

	////////////////////
	// Stage 3
	ib_lut2_stage #(.QUAN_SIZE(QUAN_SIZE)) i_lut_dec (
		.read_clk(read_clk), .rstn(rstn), .in_a(td), .in_b(e2_d2), .out(dec_idx)
	);

	// Output register with first-iteration bypass
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			v2c_valid <= 1'b0;
			v2c0      <= '0;
			v2c1      <= '0;
			v2c2      <= '0;
		end else begin
			v2c_valid <= vld_d2;
			if (tag_d2 == V2C_SRC_CHANNEL) begin
				v2c0 <= ch_d2;
				v2c1 <= ch_d2;
				v2c2 <= ch_d2;
			end else begin
				v2c0 <= m0;
				v2c1 <= m1;
				v2c2 <= m2;
			end
		end
	end

	// Index below the offset means a negative level
	assign hard_bit = ~dec_idx[QUAN_SIZE-1];

endmodule

//--- iter_counter.sv
`timescale 1ns/1ps

module iter_counter #(
	parameter  int MAX_ITER = 5,
	localparam int ITER_W   = $clog2(MAX_ITER + 1)
) (
	input  logic              read_clk,
	input  logic              rstn,
	input  logic              clear,
	input  logic              inc,
	output logic [ITER_W-1:0] iter_idx,
	output logic              last_iter
);

	localparam logic [ITER_W-1:0] CNT_LAST = ITER_W'(MAX_ITER - 1);
	localparam logic [ITER_W-1:0] CNT_MAX  = ITER_W'(MAX_ITER);

	// Counts completed iterations of the current decode
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			iter_idx <= '0;
		end else if (clear) begin
			iter_idx <= '0;
		end else if (inc && (iter_idx != CNT_MAX)) begin
			// Holds at MAX_ITER once every iteration is done
			iter_idx <= iter_idx + ITER_W'(1);
		end
	end

	// The iteration now running is the last one
	assign last_iter = (iter_idx == CNT_LAST);

endmodule

//--- iter_ctrl_fsm.sv
`timescale 1ns/1ps

module iter_ctrl_fsm
	import ib_msg_pkg::*;
	import ib_ctrl_pkg::*;
#(
	parameter int MAX_ITER = 5
) (
	input  logic     read_clk,
	input  logic     rstn,
	input  logic     start,
	input  logic     iter_end,
	input  logic     last_iter,
	output logic     cnt_clear,
	output logic     cnt_inc,
	output logic     accept,
	output v2c_src_e v2c_src,
	output logic     busy,
	output logic     done
);

	// A single-iteration decode never enters ITERATE
	localparam bit MULTI_ITER = (MAX_ITER > 1);

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	////////////////////
	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = FIRST_ITER;
				end
			end
			FIRST_ITER: begin
				if (iter_end) begin
					state_nxt = (last_iter || !MULTI_ITER) ? FINISH : ITERATE;
				end
			end
			ITERATE: begin
				if (iter_end && last_iter) begin
					state_nxt = FINISH;
				end
			end
			FINISH: begin
				state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	////////////////////
	// Outputs
	// start outside IDLE is dropped
	assign cnt_clear = (state == IDLE) && start;
	assign accept    = (state == FIRST_ITER) || (state == ITERATE);
	assign cnt_inc   = accept && iter_end;
	assign v2c_src   = (state == FIRST_ITER) ? V2C_SRC_CHANNEL : V2C_SRC_EXTRINSIC;
	assign busy      = (state != IDLE);
	assign done      = (state == FINISH);

endmodule

//--- vnu3_top.sv
`timescale 1ns/1ps

module vnu3_top
	import ib_msg_pkg::*;
#(
	parameter  int QUAN_SIZE = 4,
	parameter  int MAX_ITER  = 5,
	localparam int ITER_W    = $clog2(MAX_ITER + 1)
) (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic                 start,
	input  logic                 iter_end,
	input  logic                 msg_valid,
	input  logic [QUAN_SIZE-1:0] ch_llr,
	input  logic [QUAN_SIZE-1:0] c2v0,
	input  logic [QUAN_SIZE-1:0] c2v1,
	input  logic [QUAN_SIZE-1:0] c2v2,
	output logic                 v2c_valid,
	output logic [QUAN_SIZE-1:0] v2c0,
	output logic [QUAN_SIZE-1:0] v2c1,
	output logic [QUAN_SIZE-1:0] v2c2,
	output logic                 hard_bit,
	output logic                 busy,
	output logic                 done,
	output logic [ITER_W-1:0]    iter_idx
);

	v2c_src_e v2c_src;
	logic     accept;
	logic     cnt_clear;
	logic     cnt_inc;
	logic     last_iter;
	logic     acc_valid;

	// Messages outside an iteration are not taken in
	assign acc_valid = msg_valid & accept;

	iter_ctrl_fsm #(.MAX_ITER(MAX_ITER)) i_fsm (
		.read_clk(read_clk), .rstn(rstn),
		.start(start), .iter_end(iter_end), .last_iter(last_iter),
		.cnt_clear(cnt_clear), .cnt_inc(cnt_inc),
		.accept(accept), .v2c_src(v2c_src),
		.busy(busy), .done(done)
	);

	iter_counter #(.MAX_ITER(MAX_ITER)) i_cnt (
		.read_clk(read_clk), .rstn(rstn),
		.clear(cnt_clear), .inc(cnt_inc),
		.iter_idx(iter_idx), .last_iter(last_iter)
	);

	vnu3_datapath #(.QUAN_SIZE(QUAN_SIZE)) i_dp (
		.read_clk(read_clk), .rstn(rstn),
		.msg_valid(acc_valid), .v2c_src(v2c_src),
		.ch_llr(ch_llr), .c2v0(c2v0), .c2v1(c2v1), .c2v2(c2v2),
		.v2c_valid(v2c_valid),
		.v2c0(v2c0), .v2c1(v2c1), .v2c2(v2c2),
		.hard_bit(hard_bit)
	);

endmodule

//--- vnu3_checker.sv
`timescale 1ns/1ps

module vnu3_checker
	import ib_msg_pkg::*;
#(
	parameter  int QUAN_SIZE = 4,
	parameter  int MAX_ITER  = 5,
	localparam int ITER_W    = $clog2(MAX_ITER + 1)
) (
	input logic                 read_clk,
	input logic                 rstn,
	input logic                 start,
	input logic                 iter_end,
	input logic                 msg_valid,
	input logic [QUAN_SIZE-1:0] ch_llr,
	input logic [QUAN_SIZE-1:0] c2v0,
	input logic [QUAN_SIZE-1:0] c2v1,
	input logic [QUAN_SIZE-1:0] c2v2,
	input logic                 v2c_valid,
	input logic [QUAN_SIZE-1:0] v2c0,
	input logic [QUAN_SIZE-1:0] v2c1,
	input logic [QUAN_SIZE-1:0] v2c2,
	input logic                 hard_bit,
	input logic                 busy,
	input logic                 done,
	input logic [ITER_W-1:0]    iter_idx
);

	localparam int OFF = 2 ** (QUAN_SIZE - 1);

	int err_cnt = 0;

	// Clamped sum of two offset-binary indices
	function automatic logic [QUAN_SIZE-1:0] csum(input logic [QUAN_SIZE-1:0] a,
			input logic [QUAN_SIZE-1:0] b);
		int s;
		s = (int'(a) - OFF) + (int'(b) - OFF);
		if (s > OFF - 1) begin
			s = OFF - 1;
		end
		if (s < -OFF) begin
			s = -OFF;
		end
		return QUAN_SIZE'(s + OFF);
	endfunction

	logic                 acc_now;
	logic                 chan_now;
	logic [QUAN_SIZE-1:0] exp0_now;
	logic [QUAN_SIZE-1:0] exp1_now;
	logic [QUAN_SIZE-1:0] exp2_now;
	logic                 exp_hb_now;

	// FIRST_ITER is the only busy state with a zero count
	assign acc_now    = msg_valid && busy && !done;
	assign chan_now   = busy && !done && (iter_idx == '0);
	assign exp0_now   = csum(csum(ch_llr, c2v1), c2v2);
	assign exp1_now   = csum(csum(ch_llr, c2v0), c2v2);
	assign exp2_now   = csum(csum(ch_llr, c2v0), c2v1);
	assign exp_hb_now = int'(csum(csum(csum(ch_llr, c2v0), c2v1), c2v2)) < OFF;

	////////////////////
	// Datapath
	a_valid: assert property (@(posedge read_clk) disable iff (!rstn)
		v2c_valid == $past(acc_now, VNU_LATENCY))
		else begin
			err_cnt++;
			$error("Fail v2c_valid expected %h got %h",
				$past(acc_now, VNU_LATENCY), v2c_valid);
		end

	a_bypass: assert property (@(posedge read_clk) disable iff (!rstn)
		v2c_valid && $past(chan_now, VNU_LATENCY) |->
		v2c0 == $past(ch_llr, VNU_LATENCY) && v2c1 == v2c0 && v2c2 == v2c0)
		else begin
			err_cnt++;
			$error("Fail v2c bypass expected %h got %h %h %h",
				$past(ch_llr, VNU_LATENCY), v2c0, v2c1, v2c2);
		end

	a_extr0: assert property (@(posedge read_clk) disable iff (!rstn)
		v2c_valid && !$past(chan_now, VNU_LATENCY) |->
		v2c0 == $past(exp0_now, VNU_LATENCY))
		else begin
			err_cnt++;
			$error("Fail v2c0 expected %h got %h",
				$past(exp0_now, VNU_LATENCY), v2c0);
		end

	a_extr1: assert property (@(posedge read_clk) disable iff (!rstn)
		v2c_valid && !$past(chan_now, VNU_LATENCY) |->
		v2c1 == $past(exp1_now, VNU_LATENCY))
		else begin
			err_cnt++;
			$error("Fail v2c1 expected %h got %h",
				$past(exp1_now, VNU_LATENCY), v2c1);
		end

	a_extr2: assert property (@(posedge read_clk) disable iff (!rstn)
		v2c_valid && !$past(chan_now, VNU_LATENCY) |->
		v2c2 == $past(exp2_now, VNU_LATENCY))
		else begin
			err_cnt++;
			$error("Fail v2c2 expected %h got %h",
				$past(exp2_now, VNU_LATENCY), v2c2);
		end

	a_hard: assert property (@(posedge read_clk) disable iff (!rstn)
		v2c_valid |-> hard_bit == $past(exp_hb_now, VNU_LATENCY))
		else begin
			err_cnt++;
			$error("Fail hard_bit expected %h got %h",
				$past(exp_hb_now, VNU_LATENCY), hard_bit);
		end

	////////////////////
	// Controller
	// No decode begins without start
	a_idle: assert property (@(posedge read_clk) disable iff (!rstn)
		!busy && !start |=> !busy && !done)
		else begin
			err_cnt++;
			$error("busy or done rose with no start");
		end

	a_start: assert property (@(posedge read_clk) disable iff (!rstn)
		start && !busy |=> busy && iter_idx == '0)
		else begin
			err_cnt++;
			$error("Fail iter_idx got %h after start", iter_idx);
		end

	a_step: assert property (@(posedge read_clk) disable iff (!rstn)
		iter_end && busy && !done |=> int'(iter_idx) == int'($past(iter_idx)) + 1)
		else begin
			err_cnt++;
			$error("Fail iter_idx got %h", iter_idx);
		end

	a_busy_start: assert property (@(posedge read_clk) disable iff (!rstn)
		start && busy && !done && !iter_end |=> busy && $stable(iter_idx))
		else begin
			err_cnt++;
			$error("start while busy changed the decode");
		end

	a_done: assert property (@(posedge read_clk) disable iff (!rstn)
		done |-> int'(iter_idx) == MAX_ITER ##1 !done && !busy)
		else begin
			err_cnt++;
			$error("Fail done pulse with iter_idx %h", iter_idx);
		end

endmodule

//--- tb_vnu3.sv
`timescale 1ns/1ps

module tb_vnu3
	import ib_msg_pkg::*;
();

	localparam int QUAN_SIZE = 4;
	localparam int MAX_ITER  = 5;
	localparam int ITER_W    = $clog2(MAX_ITER + 1);
	// Test lengths in cycles and the run limit with margin
	localparam int TEST_CYCLES = 10 + 12 + 16 + 10 + 24 + 30;
	localparam int CYCLE_LIMIT = TEST_CYCLES + 60;

	logic                 read_clk;
	logic                 rstn;
	logic                 start;
	logic                 iter_end;
	logic                 msg_valid;
	logic [QUAN_SIZE-1:0] ch_llr;
	logic [QUAN_SIZE-1:0] c2v0;
	logic [QUAN_SIZE-1:0] c2v1;
	logic [QUAN_SIZE-1:0] c2v2;
	logic                 v2c_valid;
	logic [QUAN_SIZE-1:0] v2c0;
	logic [QUAN_SIZE-1:0] v2c1;
	logic [QUAN_SIZE-1:0] v2c2;
	logic                 hard_bit;
	logic                 busy;
	logic                 done;
	logic [ITER_W-1:0]    iter_idx;

	int cycles = 0;
	int tests  = 0;
	int fails  = 0;
	int last_errs = 0;

	vnu3_top #(.QUAN_SIZE(QUAN_SIZE), .MAX_ITER(MAX_ITER)) i_dut (.*);

	bind vnu3_top vnu3_checker #(.QUAN_SIZE(QUAN_SIZE), .MAX_ITER(MAX_ITER)) i_chk (.*);

	initial read_clk = 1'b0;
	always #50 read_clk = ~read_clk;

	always @(posedge read_clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	// One cycle of stimulus set up on the falling edge
	task automatic drive_cycle(input logic vld, input logic [QUAN_SIZE-1:0] ch,
			input logic [QUAN_SIZE-1:0] e0, input logic [QUAN_SIZE-1:0] e1,
			input logic [QUAN_SIZE-1:0] e2, input logic ie, input logic st);
		@(negedge read_clk);
		msg_valid = vld;
		ch_llr    = ch;
		c2v0      = e0;
		c2v1      = e1;
		c2v2      = e2;
		iter_end  = ie;
		start     = st;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle(1'b0, '0, '0, '0, '0, 1'b0, 1'b0);
	endtask

	task automatic send_corners();
		drive_cycle(1'b1, 4'h0, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0);
		drive_cycle(1'b1, 4'hf, 4'hf, 4'hf, 4'hf, 1'b0, 1'b0);
		drive_cycle(1'b1, 4'h8, 4'h8, 4'h8, 4'h8, 1'b0, 1'b0);
		drive_cycle(1'b1, 4'hc, 4'h1, 4'hf, 4'h3, 1'b0, 1'b0);
		drive_cycle(1'b1, 4'h2, 4'hd, 4'h0, 4'ha, 1'b0, 1'b0);
		drive_cycle(1'b1, 4'h7, 4'h9, 4'h6, 4'hb, 1'b0, 1'b0);
		idle_cycles(VNU_LATENCY + 1);
	endtask

	// Closes a test with its report line
	task automatic report_test(input string name);
		int errs;
		errs = i_dut.i_chk.err_cnt - last_errs;
		last_errs = i_dut.i_chk.err_cnt;
		tests++;
		$display("%s: %0d assertion failures", name, errs);
	endtask

	initial begin
		int tries;
		rstn      = 1'b0;
		start     = 1'b0;
		iter_end  = 1'b0;
		msg_valid = 1'b0;
		ch_llr    = '0;
		c2v0      = '0;
		c2v1      = '0;
		c2v2      = '0;
		repeat (10) @(posedge read_clk);
		@(negedge read_clk);
		rstn = 1'b1;

		// Messages before start must not come out
		drive_cycle(1'b1, 4'h5, 4'h3, 4'h9, 4'he, 1'b0, 1'b0);
		drive_cycle(1'b1, 4'hf, 4'h0, 4'h0, 4'hf, 1'b0, 1'b0);
		idle_cycles(VNU_LATENCY + 2);
		report_test("idle before start");

		drive_cycle(1'b0, '0, '0, '0, '0, 1'b0, 1'b1);
		send_corners();
		report_test("first iteration bypass");

		// Strobes straddle the iteration change
		drive_cycle(1'b1, 4'h3, 4'h9, 4'hc, 4'h5, 1'b0, 1'b0);
		drive_cycle(1'b1, 4'he, 4'h2, 4'h7, 4'hb, 1'b1, 1'b0);
		drive_cycle(1'b1, 4'h6, 4'hd, 4'h1, 4'ha, 1'b0, 1'b0);
		drive_cycle(1'b1, 4'h0, 4'hf, 4'h4, 4'h8, 1'b0, 1'b0);
		idle_cycles(VNU_LATENCY + 1);
		report_test("tags across iter_end");

		send_corners();
		report_test("extrinsic iteration");

		drive_cycle(1'b0, '0, '0, '0, '0, 1'b0, 1'b1);
		tries = 0;
		while (!done && tries < MAX_ITER + 1) begin
			drive_cycle(1'b1, 4'h9, 4'h4, 4'hb, 4'h6, 1'b1, 1'b0);
			idle_cycles(1);
			tries++;
		end
		if (!done) begin
			fails++;
			$display("done did not pulse after %0d iter_end strobes", tries);
		end
		idle_cycles(VNU_LATENCY + 2);
		report_test("iteration limit");

		fails += i_dut.i_chk.err_cnt;
		$display("%0d tests, %0d failures", tests, fails);
		if (fails == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
ib_msg_pkg.sv
ib_ctrl_pkg.sv
ib_lut2_stage.sv
c2v_delay_line.sv
vnu3_datapath.sv
iter_counter.sv
iter_ctrl_fsm.sv
vnu3_top.sv
vnu3_checker.sv
tb_vnu3.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --assert --timing --top-module tb_vnu3 -f project.f -o sim_vnu3 \
	&& ./obj_dir/sim_vnu3 +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Test FAILED" >> sim.log

cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
